// ==== common/gat_consts.svh ====
`ifndef GAT_CONSTS_SVH
`define GAT_CONSTS_SVH

// Datapath sizes
`define GAT_DATA_W      8
`define GAT_IN_FEATS    8
`define GAT_OUT_FEATS   4
`define GAT_ACC_W       20
`define GAT_SCORE_W     30
`define GAT_ROW_W       8
`define GAT_FIFO_DEPTH  4

// Wishbone register map, word addresses
`define GAT_WB_ADR_W    6
`define GAT_REG_CTRL    0
`define GAT_REG_STATUS  1
`define GAT_REG_W_BASE  8
`define GAT_REG_A_BASE  40

`endif

// ==== common/gat_pkg.sv ====
`include "gat_consts.svh"

package gat_pkg;

  typedef logic [`GAT_DATA_W-1:0] data_t;
  typedef logic [`GAT_OUT_FEATS-1:0][`GAT_ACC_W-1:0] wh_feats_t;
  typedef data_t [`GAT_OUT_FEATS-1:0] w_row_t;
  typedef data_t [`GAT_OUT_FEATS-1:0] a_vec_t;
  typedef logic [`GAT_SCORE_W-1:0] score_t;
  typedef logic [`GAT_ROW_W-1:0] row_id_t;
  typedef logic [31:0] wb_data_t;

  // One record per finished row
  typedef struct packed {
    row_id_t   row;
    wh_feats_t feats;
    score_t    score;
  } gat_result_t;

  typedef enum logic {SPMM_ACCUM, SPMM_EMIT} spmm_state_e;
  typedef enum logic [1:0] {ATTN_IDLE, ATTN_MAC, ATTN_PUSH} attn_state_e;
  typedef enum logic [2:0] {
    REGION_CTRL, REGION_STATUS, REGION_W, REGION_A, REGION_NONE
  } cfg_region_e;

endpackage

// ==== common/wh_if.sv ====
interface wh_if import gat_pkg::*; ();

  logic      valid;
  logic      ready;
  row_id_t   row;
  wh_feats_t feats;

  // Producer side, SPMM engine
  modport src (output valid, output row, output feats, input ready);

  // Consumer side, attention unit
  modport dst (input valid, input row, input feats, output ready);

endinterface

// ==== src/gat_cfg_regs.sv ====
`include "gat_consts.svh"

module gat_cfg_regs import gat_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [`GAT_WB_ADR_W-1:0]      wb_adr_i,
  input  wb_data_t                      wb_dat_i,
  output wb_data_t                      wb_dat_o,
  output logic                          wb_ack_o,
  input  logic [$clog2(`GAT_IN_FEATS)-1:0] w_sel_i,
  output w_row_t                        w_row_o,
  output a_vec_t                        a_vec_o,
  output logic                          enable_o,
  input  logic                          row_done_i
);

  cfg_region_e               region;
  logic                      ack_q;
  logic                      wr_en;
  logic                      enable_q;
  wb_data_t                  row_cnt_q;
  logic [`GAT_WB_ADR_W-1:0]  w_off;
  logic [`GAT_WB_ADR_W-1:0]  a_off;
  w_row_t                    w_mem [`GAT_IN_FEATS];
  a_vec_t                    a_q;

  always_comb begin
    region = REGION_NONE;
    if (wb_adr_i == `GAT_REG_CTRL)
      region = REGION_CTRL;
    else if (wb_adr_i == `GAT_REG_STATUS)
      region = REGION_STATUS;
    else if (wb_adr_i >= `GAT_REG_W_BASE &&
             wb_adr_i < `GAT_REG_W_BASE + `GAT_IN_FEATS * `GAT_OUT_FEATS)
      region = REGION_W;
    else if (wb_adr_i >= `GAT_REG_A_BASE && wb_adr_i < `GAT_REG_A_BASE + `GAT_OUT_FEATS)
      region = REGION_A;
  end

  // Row in bits 4:2, feature in bits 1:0
  assign w_off = wb_adr_i - `GAT_REG_W_BASE;
  assign a_off = wb_adr_i - `GAT_REG_A_BASE;

  assign wb_ack_o = ack_q && wb_cyc_i && wb_stb_i;
  assign wr_en    = wb_ack_o && wb_we_i;

  always_comb begin
    case (region)
      REGION_CTRL:   wb_dat_o = wb_data_t'(enable_q);
      REGION_STATUS: wb_dat_o = row_cnt_q;
      REGION_W:      wb_dat_o = wb_data_t'(w_mem[w_off[4:2]][w_off[1:0]]);
      REGION_A:      wb_dat_o = wb_data_t'(a_q[a_off[1:0]]);
      default:       wb_dat_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q     <= 1'b0;
      enable_q  <= 1'b0;
      row_cnt_q <= '0;
    end else begin
      ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
      if (wr_en && region == REGION_CTRL)
        enable_q <= wb_dat_i[0];
      // A status write wins over a finishing row
      if (wr_en && region == REGION_STATUS)
        row_cnt_q <= '0;
      else if (row_done_i)
        row_cnt_q <= row_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && region == REGION_W)
      w_mem[w_off[4:2]][w_off[1:0]] <= wb_dat_i[`GAT_DATA_W-1:0];
    if (wr_en && region == REGION_A)
      a_q[a_off[1:0]] <= wb_dat_i[`GAT_DATA_W-1:0];
  end

  assign w_row_o  = w_mem[w_sel_i];
  assign a_vec_o  = a_q;
  assign enable_o = enable_q;

  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i));

endmodule

// ==== spmm/spmm_row_engine.sv ====
`include "gat_consts.svh"

module spmm_row_engine import gat_pkg::*; (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             enable_i,
  input  logic                             h_valid_i,
  input  logic [$clog2(`GAT_IN_FEATS)-1:0] h_col_i,
  input  data_t                            h_val_i,
  input  logic                             h_last_i,
  output logic                             h_ready_o,
  output logic [$clog2(`GAT_IN_FEATS)-1:0] w_sel_o,
  input  w_row_t                           w_row_i,
  wh_if.src                                wh
);

  spmm_state_e              state_q;
  wh_feats_t                acc_q;
  row_id_t                  row_q;
  logic                     h_fire;
  logic                     wh_fire;
  logic [2*`GAT_DATA_W-1:0] prod [`GAT_OUT_FEATS];

  // W row lookup follows the column of the entry on the bus
  assign w_sel_o = h_col_i;

  assign h_ready_o = enable_i && (state_q == SPMM_ACCUM);
  assign h_fire    = h_valid_i && h_ready_o;
  assign wh_fire   = wh.valid && wh.ready;

  always_comb begin
    for (int f = 0; f < `GAT_OUT_FEATS; f++) begin
      prod[f] = h_val_i * w_row_i[f];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= SPMM_ACCUM;
      acc_q   <= '0;
      row_q   <= '0;
    end else begin
      case (state_q)
        SPMM_ACCUM: begin
          if (h_fire) begin
            for (int f = 0; f < `GAT_OUT_FEATS; f++) begin
              acc_q[f] <= acc_q[f] + prod[f];
            end
            if (h_last_i)
              state_q <= SPMM_EMIT;
          end
        end
        SPMM_EMIT: begin
          // Row handed over, start the next one from zero
          if (wh_fire) begin
            acc_q   <= '0;
            row_q   <= row_q + 1'b1;
            state_q <= SPMM_ACCUM;
          end
        end
        default: begin
          state_q <= SPMM_ACCUM;
        end
      endcase
    end
  end

  assign wh.valid = (state_q == SPMM_EMIT);
  assign wh.row   = row_q;
  assign wh.feats = acc_q;

  // After the last entry, input stays closed until the row is taken
  a_no_accept_in_emit: assert property (@(posedge clk) disable iff (!rst_n)
    (h_fire && h_last_i) |=> (wh.valid && !h_fire) until_with wh_fire);

endmodule

// ==== src/attn_score.sv ====
`include "gat_consts.svh"

module attn_score import gat_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  wh_if.dst           wh,
  input  a_vec_t      a_vec_i,
  input  logic        fifo_full_i,
  output logic        push_o,
  output gat_result_t push_data_o,
  output logic        row_done_o
);

  attn_state_e                       state_q;
  logic [$clog2(`GAT_OUT_FEATS)-1:0] step_q;
  row_id_t                           row_q;
  wh_feats_t                         feats_q;
  score_t                            score_q;

  assign wh.ready   = (state_q == ATTN_IDLE);
  assign push_o     = (state_q == ATTN_PUSH) && !fifo_full_i;
  assign row_done_o = push_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ATTN_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        ATTN_IDLE: begin
          step_q <= '0;
          if (wh.valid)
            state_q <= ATTN_MAC;
        end
        ATTN_MAC: begin
          step_q <= step_q + 1'b1;
          if (step_q == `GAT_OUT_FEATS - 1)
            state_q <= ATTN_PUSH;
        end
        ATTN_PUSH: begin
          if (!fifo_full_i)
            state_q <= ATTN_IDLE;
        end
        default: state_q <= ATTN_IDLE;
      endcase
    end
  end

  // One feature per cycle into the score
  always_ff @(posedge clk) begin
    if (state_q == ATTN_IDLE && wh.valid) begin
      row_q   <= wh.row;
      feats_q <= wh.feats;
      score_q <= '0;
    end else if (state_q == ATTN_MAC) begin
      score_q <= score_q + feats_q[step_q] * a_vec_i[step_q];
    end
  end

  always_comb begin
    push_data_o.row   = row_q;
    push_data_o.feats = feats_q;
    push_data_o.score = score_q;
  end

  // A result held back by a full FIFO stays unchanged
  a_hold_while_full: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == ATTN_PUSH && fifo_full_i) |=> $stable(push_data_o));

endmodule

// ==== src/result_fifo.sv ====
`include "gat_consts.svh"

module result_fifo import gat_pkg::*; #(
  parameter int DEPTH = `GAT_FIFO_DEPTH
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push_i,
  input  gat_result_t push_data_i,
  input  logic        pop_i,
  output gat_result_t pop_data_o,
  output logic        full_o,
  output logic        empty_o
);

  localparam int PTR_W = $clog2(DEPTH);

  gat_result_t      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  assign full_o     = (count_q == DEPTH);
  assign empty_o    = (count_q == 0);
  assign pop_data_o = mem[rd_ptr_q];

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + push_i - pop_i;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i)
      mem[wr_ptr_q] <= push_data_i;
  end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);

endmodule

// ==== src/gat_scheduler.sv ====
`include "gat_consts.svh"

module gat_scheduler import gat_pkg::*; (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   wb_cyc_i,
  input  logic                                   wb_stb_i,
  input  logic                                   wb_we_i,
  input  logic [`GAT_WB_ADR_W-1:0]               wb_adr_i,
  input  wb_data_t                               wb_dat_i,
  output wb_data_t                               wb_dat_o,
  output logic                                   wb_ack_o,
  input  logic                                   h_valid_i,
  input  logic [$clog2(`GAT_IN_FEATS)-1:0]       h_col_i,
  input  data_t                                  h_val_i,
  input  logic                                   h_last_i,
  output logic                                   h_ready_o,
  output logic                                   res_valid_o,
  input  logic                                   res_ready_i,
  output row_id_t                                res_row_o,
  output logic [`GAT_OUT_FEATS*`GAT_ACC_W-1:0]   res_feats_o,
  output score_t                                 res_score_o
);

  logic [$clog2(`GAT_IN_FEATS)-1:0] w_sel;
  w_row_t                           w_row;
  a_vec_t                           a_vec;
  logic                             enable;
  logic                             row_done;
  logic                             push;
  gat_result_t                      push_data;
  gat_result_t                      pop_data;
  logic                             fifo_full;
  logic                             fifo_empty;
  logic                             pop;

  wh_if u_wh ();

  gat_cfg_regs u_cfg_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .w_sel_i    (w_sel),
    .w_row_o    (w_row),
    .a_vec_o    (a_vec),
    .enable_o   (enable),
    .row_done_i (row_done)
  );

  spmm_row_engine u_spmm (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable_i  (enable),
    .h_valid_i (h_valid_i),
    .h_col_i   (h_col_i),
    .h_val_i   (h_val_i),
    .h_last_i  (h_last_i),
    .h_ready_o (h_ready_o),
    .w_sel_o   (w_sel),
    .w_row_i   (w_row),
    .wh        (u_wh.src)
  );

  attn_score u_attn (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh          (u_wh.dst),
    .a_vec_i     (a_vec),
    .fifo_full_i (fifo_full),
    .push_o      (push),
    .push_data_o (push_data),
    .row_done_o  (row_done)
  );

  result_fifo #(
    .DEPTH (`GAT_FIFO_DEPTH)
  ) u_res_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .full_o      (fifo_full),
    .empty_o     (fifo_empty)
  );

  assign res_valid_o = !fifo_empty;
  assign pop         = res_valid_o && res_ready_i;
  assign res_row_o   = pop_data.row;
  assign res_feats_o = pop_data.feats;
  assign res_score_o = pop_data.score;

endmodule

// ==== testbench/tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== testbench/tb_gat_scheduler.sv ====
`include "gat_consts.svh"

module tb_gat_scheduler import gat_pkg::*;;

  localparam int N_SINGLE = `GAT_IN_FEATS;
  localparam int N_BUSY   = 20;
  localparam int N_STALL  = 12;
  localparam int N_ROWS   = N_SINGLE + N_BUSY + N_STALL;
  localparam int N_UNMAP  = 6;
  localparam int N_WB     = 2 * (`GAT_IN_FEATS * `GAT_OUT_FEATS + `GAT_OUT_FEATS + 1)
                            + N_UNMAP + 4;

  logic                             clk;
  logic                             rst_n;
  logic                             wb_cyc_i;
  logic                             wb_stb_i;
  logic                             wb_we_i;
  logic [`GAT_WB_ADR_W-1:0]         wb_adr_i;
  wb_data_t                         wb_dat_i;
  wb_data_t                         wb_dat_o;
  logic                             wb_ack_o;
  logic                             h_valid_i;
  logic [$clog2(`GAT_IN_FEATS)-1:0] h_col_i;
  data_t                            h_val_i;
  logic                             h_last_i;
  logic                             h_ready_o;
  logic                             res_valid_o;
  logic                             res_ready_i;
  row_id_t                          res_row_o;
  wh_feats_t                        res_feats_o;
  score_t                           res_score_o;

  // Reference copies of the configuration and of every row sent
  data_t      w_ref [`GAT_IN_FEATS][`GAT_OUT_FEATS];
  data_t      a_ref [`GAT_OUT_FEATS];
  int         row_len [N_ROWS];
  logic [2:0] row_col [N_ROWS][`GAT_IN_FEATS];
  data_t      row_val [N_ROWS][`GAT_IN_FEATS];
  int         unmapped [N_UNMAP] = '{2, 5, 7, 44, 51, 63};
  int         exp_q [$];
  integer     seed = 32'hf096a022;
  int         limit;
  int         cycles;
  logic       stall_mode;
  int         stall_left;
  row_id_t    exp_row;

  tb_clk_gen #(
    .PERIOD     (40),
    .RST_CYCLES (10)
  ) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_scheduler DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .h_valid_i   (h_valid_i),
    .h_col_i     (h_col_i),
    .h_val_i     (h_val_i),
    .h_last_i    (h_last_i),
    .h_ready_o   (h_ready_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_row_o   (res_row_o),
    .res_feats_o (res_feats_o),
    .res_score_o (res_score_o)
  );

  task automatic stop_run(string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_feats(wh_feats_t got, wh_feats_t want, string what);
    if (got !== want)
      stop_run($sformatf("mismatch at time %0t: %s got %h, expected %h", $time, what, got, want));
  endtask

  task automatic check_score(score_t got, score_t want, string what);
    if (got !== want)
      stop_run($sformatf("mismatch at time %0t: %s got %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic check_row(row_id_t got, row_id_t want, string what);
    if (got !== want)
      stop_run($sformatf("mismatch at time %0t: %s got %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic check_word(wb_data_t got, wb_data_t want, string what);
    if (got !== want)
      stop_run($sformatf("mismatch at time %0t: %s got %h, expected %h", $time, what, got, want));
  endtask

  // WH row as the sum of value times W row, score as a dotted with it
  function automatic gat_result_t ref_row(int idx, row_id_t id);
    logic [63:0] acc [`GAT_OUT_FEATS];
    logic [63:0] sc;
    gat_result_t res;
    sc = '0;
    for (int f = 0; f < `GAT_OUT_FEATS; f++) begin
      acc[f] = '0;
      for (int e = 0; e < row_len[idx]; e++)
        acc[f] = acc[f] + row_val[idx][e] * w_ref[row_col[idx][e]][f];
      sc = sc + acc[f] * a_ref[f];
    end
    res.row = id;
    for (int f = 0; f < `GAT_OUT_FEATS; f++)
      res.feats[f] = acc[f][`GAT_ACC_W-1:0];
    res.score = sc[`GAT_SCORE_W-1:0];
    return res;
  endfunction

  task automatic make_stimulus();
    for (int r = 0; r < `GAT_IN_FEATS; r++)
      for (int f = 0; f < `GAT_OUT_FEATS; f++)
        w_ref[r][f] = data_t'($random(seed));
    for (int f = 0; f < `GAT_OUT_FEATS; f++)
      a_ref[f] = data_t'($random(seed));
    for (int r = 0; r < N_ROWS; r++) begin
      row_len[r] = 1 + ($random(seed) & 7);
      for (int e = 0; e < `GAT_IN_FEATS; e++) begin
        row_col[r][e] = 3'($random(seed));
        row_val[r][e] = data_t'($random(seed));
        if (($random(seed) & 3) == 0)
          row_val[r][e] = '0;
      end
      if (r < N_SINGLE) begin
        row_len[r]    = 1;
        row_col[r][0] = 3'(r);
      end
    end
    // First busy row always repeats a column and carries a zero
    row_len[N_SINGLE]    = 4;
    row_col[N_SINGLE][1] = row_col[N_SINGLE][0];
    row_val[N_SINGLE][2] = '0;
    limit = 100 + 4 * N_WB;
    for (int r = 0; r < N_ROWS; r++)
      limit = limit + 3 * (row_len[r] + 12);
  endtask

  // Called on a falling edge; holds the request until the cycle after ack
  task automatic wb_access(logic we, int adr, wb_data_t wdata, output wb_data_t rdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr[`GAT_WB_ADR_W-1:0];
    wb_dat_i = wdata;
    @(negedge clk);
    while (!wb_ack_o)
      @(negedge clk);
    rdata = wb_dat_o;
    @(negedge clk);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(int adr, wb_data_t wdata);
    wb_data_t unused;
    wb_access(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(int adr, output wb_data_t rdata);
    wb_access(1'b0, adr, '0, rdata);
  endtask

  task automatic send_row(int idx);
    exp_q.push_back(idx);
    for (int e = 0; e < row_len[idx]; e++) begin
      h_valid_i = 1'b1;
      h_col_i   = row_col[idx][e];
      h_val_i   = row_val[idx][e];
      h_last_i  = (e == row_len[idx] - 1);
      while (!h_ready_o)
        @(negedge clk);
      @(negedge clk);
    end
  endtask

  initial begin : watchdog
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > limit)
        stop_run($sformatf("Error: no result arrived in time, limit of %0d cycles passed",
                           limit));
    end
  end

  initial begin : result_checker
    gat_result_t want;
    int          idx;
    exp_row    = '0;
    stall_left = 0;
    forever begin
      @(negedge clk);
      // Long stalls fill the FIFO, short ones come from a coin toss
      if (!stall_mode) begin
        res_ready_i = 1'b1;
      end else if (stall_left > 0) begin
        res_ready_i = 1'b0;
        stall_left--;
      end else if (($random(seed) & 15) == 0) begin
        res_ready_i = 1'b0;
        stall_left  = 24 + ($random(seed) & 15);
      end else begin
        res_ready_i = 1'($random(seed));
      end
      // The pop happens on the coming rising edge
      if (rst_n && res_valid_o && res_ready_i) begin
        if (exp_q.size() == 0)
          stop_run("Error: a result came out with no row outstanding");
        idx  = exp_q.pop_front();
        want = ref_row(idx, exp_row);
        check_row(res_row_o, want.row, "row id");
        check_feats(res_feats_o, want.feats, "features");
        check_score(res_score_o, want.score, "score");
        exp_row = exp_row + 1'b1;
      end
    end
  end

  initial begin : main
    wb_data_t rd;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    h_valid_i   = 1'b0;
    h_col_i     = '0;
    h_val_i     = '0;
    h_last_i    = 1'b0;
    res_ready_i = 1'b0;
    stall_mode  = 1'b0;
    make_stimulus();
    wait (rst_n === 1'b1);
    @(negedge clk);

    for (int r = 0; r < `GAT_IN_FEATS; r++)
      for (int f = 0; f < `GAT_OUT_FEATS; f++)
        wb_write(`GAT_REG_W_BASE + r * `GAT_OUT_FEATS + f, wb_data_t'(w_ref[r][f]));
    for (int f = 0; f < `GAT_OUT_FEATS; f++)
      wb_write(`GAT_REG_A_BASE + f, wb_data_t'(a_ref[f]));
    wb_write(`GAT_REG_CTRL, 32'd1);
    for (int r = 0; r < `GAT_IN_FEATS; r++) begin
      for (int f = 0; f < `GAT_OUT_FEATS; f++) begin
        wb_read(`GAT_REG_W_BASE + r * `GAT_OUT_FEATS + f, rd);
        check_word(rd, wb_data_t'(w_ref[r][f]), "W readback");
      end
    end
    for (int f = 0; f < `GAT_OUT_FEATS; f++) begin
      wb_read(`GAT_REG_A_BASE + f, rd);
      check_word(rd, wb_data_t'(a_ref[f]), "a readback");
    end
    wb_read(`GAT_REG_CTRL, rd);
    check_word(rd, 32'd1, "control readback");
    for (int u = 0; u < N_UNMAP; u++) begin
      wb_read(unmapped[u], rd);
      check_word(rd, '0, "unmapped read");
    end

    // Single entries, then a busy stream, then the same under back-pressure
    for (int r = 0; r < N_SINGLE + N_BUSY; r++)
      send_row(r);
    stall_mode = 1'b1;
    for (int r = N_SINGLE + N_BUSY; r < N_ROWS; r++)
      send_row(r);
    h_valid_i  = 1'b0;
    h_last_i   = 1'b0;
    stall_mode = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    @(negedge clk);

    wb_read(`GAT_REG_STATUS, rd);
    check_word(rd, wb_data_t'(N_ROWS), "status after drain");
    wb_write(`GAT_REG_STATUS, 32'hffff_ffff);
    wb_read(`GAT_REG_STATUS, rd);
    check_word(rd, '0, "status after clear");

    wb_write(`GAT_REG_CTRL, '0);
    h_valid_i = 1'b1;
    h_col_i   = '0;
    h_val_i   = 8'd1;
    h_last_i  = 1'b1;
    repeat (20) begin
      @(negedge clk);
      if (h_ready_o)
        stop_run("Error: h_ready_o went high while enable was cleared");
      if (res_valid_o)
        stop_run("Error: res_valid_o went high while enable was cleared");
    end
    h_valid_i = 1'b0;
    h_last_i  = 1'b0;

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/gat_pkg.sv
common/wh_if.sv
src/gat_cfg_regs.sv
spmm/spmm_row_engine.sv
src/attn_score.sv
src/result_fifo.sv
src/gat_scheduler.sv
testbench/tb_clk_gen.sv
testbench/tb_gat_scheduler.sv

// ==== Bender.yml ====
package:
  name: gat_scheduler

sources:
  - include_dirs:
      - common
    files:
      - common/gat_pkg.sv
      - common/wh_if.sv
      - src/gat_cfg_regs.sv
      - spmm/spmm_row_engine.sv
      - src/attn_score.sv
      - src/result_fifo.sv
      - src/gat_scheduler.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_gat_scheduler.sv
